//--- verilog/xrf_pkg.sv
package xrf_pkg;

   // register file geometry
   localparam int XRF_WIDTH      = 32;
   localparam int XRF_BYTES      = XRF_WIDTH / 8;
   localparam int XRF_DEPTH      = 64;
   localparam int XRF_ADDR_W     = $clog2(XRF_DEPTH);

   // one bank per write port
   localparam int XRF_WPORTS     = 2;
   localparam int XRF_RPORTS     = 2;
   localparam int XRF_LVT_COPIES = XRF_WPORTS - 1;

   typedef struct packed {
      logic                  en;
      logic [XRF_ADDR_W-1:0] addr;
      logic [XRF_BYTES-1:0]  bwe;
      logic [XRF_WIDTH-1:0]  data;
   } xrf_wr_req_t;

   typedef struct packed {
      logic                  en;
      logic [XRF_ADDR_W-1:0] addr;
   } xrf_rd_req_t;

   // write side of one RAM copy
   typedef struct packed {
      logic [XRF_ADDR_W-1:0] addr;
      logic [XRF_BYTES-1:0]  bwe;
      logic [XRF_WIDTH-1:0]  data;
   } xrf_ram_wr_t;

   // k-th index of a list that leaves out entry skip
   function automatic int xrf_other(int k, int skip);
      return (k < skip) ? k : k + 1;
   endfunction

   // copy slot in bank b that serves writer w
   function automatic int xrf_copy_idx(int w, int b);
      return (w < b) ? w : w - 1;
   endfunction

endpackage

//--- verilog/sdp_bwe_bram.sv
module sdp_bwe_bram
   import xrf_pkg::*;
(
   input  logic                  clk,
   input  xrf_ram_wr_t           wr_i,
   input  logic [XRF_BYTES-1:0]  we_i,
   input  logic [XRF_ADDR_W-1:0] raddr_i,
   output logic [XRF_WIDTH-1:0]  rdata_o
);

   logic [XRF_WIDTH-1:0] mem [XRF_DEPTH];
   logic [XRF_BYTES-1:0] lane_we;

   // byte lanes to write this edge
   assign lane_we = we_i & wr_i.bwe;

   always_ff @(posedge clk)
   begin
      for (int b = 0; b < XRF_BYTES; b++)
      begin
         if (lane_we[b])
         begin
            mem[wr_i.addr][b*8 +: 8] <= wr_i.data[b*8 +: 8];
         end
      end
   end

   // registered read, old word on a same-edge write
   always_ff @(posedge clk)
   begin
      rdata_o <= mem[raddr_i];
   end

endmodule

//--- verilog/xrf_write_encode.sv
module xrf_write_encode
   import xrf_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rstn,
   input  xrf_wr_req_t                              wr_i,
   input  logic [XRF_LVT_COPIES-1:0][XRF_WIDTH-1:0] others_i,
   output xrf_ram_wr_t                              ram_wr_o,
   output logic [XRF_BYTES-1:0]                     we_o
);

   xrf_wr_req_t          wr_q;
   logic [XRF_WIDTH-1:0] enc_data;

   // input register stage
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_q.en <= 1'b0;
      end
      else
      begin
         wr_q.en <= wr_i.en;
      end
   end

   always_ff @(posedge clk)
   begin
      wr_q.addr <= wr_i.addr;
      wr_q.bwe  <= wr_i.bwe;
      wr_q.data <= wr_i.data;
   end

   // fold in what the other banks hold at this address,
   // so that the XOR over all banks yields the new word
   always_comb
   begin
      enc_data = wr_q.data;
      for (int c = 0; c < XRF_LVT_COPIES; c++)
      begin
         enc_data = enc_data ^ others_i[c];
      end
   end

   assign ram_wr_o.addr = wr_q.addr;
   assign ram_wr_o.bwe  = wr_q.bwe;
   assign ram_wr_o.data = enc_data;

   // lanes only fire for a captured request
   assign we_o = wr_q.bwe & {XRF_BYTES{wr_q.en}};

endmodule

//--- verilog/xrf_bank.sv
module xrf_bank
   import xrf_pkg::*;
#(
   parameter int BANK_ID = 0
)
(
   input  logic                                     clk,
   input  xrf_ram_wr_t                              ram_wr_i,
   input  logic [XRF_BYTES-1:0]                     we_i,
   input  logic [XRF_WPORTS-1:0][XRF_ADDR_W-1:0]    copy_raddr_i,
   input  logic [XRF_RPORTS-1:0][XRF_ADDR_W-1:0]    rd_addr_i,
   output logic [XRF_LVT_COPIES-1:0][XRF_WIDTH-1:0] copy_rdata_o,
   output logic [XRF_RPORTS-1:0][XRF_WIDTH-1:0]     rd_rdata_o
);

   // copy c is read at the address of writer xrf_other(c, BANK_ID)
   logic [XRF_LVT_COPIES-1:0][XRF_ADDR_W-1:0] copy_raddr;

   generate
      for (genvar c = 0; c < XRF_LVT_COPIES; c++)
      begin : gen_copy
         assign copy_raddr[c] = copy_raddr_i[xrf_other(c, BANK_ID)];

         sdp_bwe_bram u_copy_ram
         (
            .clk     (clk),
            .wr_i    (ram_wr_i),
            .we_i    (we_i),
            .raddr_i (copy_raddr[c]),
            .rdata_o (copy_rdata_o[c])
         );
      end

      // one copy per read port, all holding the same encoded words
      for (genvar r = 0; r < XRF_RPORTS; r++)
      begin : gen_read
         sdp_bwe_bram u_read_ram
         (
            .clk     (clk),
            .wr_i    (ram_wr_i),
            .we_i    (we_i),
            .raddr_i (rd_addr_i[r]),
            .rdata_o (rd_rdata_o[r])
         );
      end
   endgenerate

endmodule

//--- verilog/xrf_read_decode.sv
module xrf_read_decode
   import xrf_pkg::*;
(
   input  logic                                                 clk,
   input  logic                                                 rstn,
   input  xrf_rd_req_t [XRF_RPORTS-1:0]                         rd_i,
   input  logic [XRF_WPORTS-1:0][XRF_RPORTS-1:0][XRF_WIDTH-1:0] bank_rdata_i,
   output logic [XRF_RPORTS-1:0][XRF_WIDTH-1:0]                 rdata_o,
   output logic [XRF_RPORTS-1:0]                                rvalid_o
);

   // valid follows the RAM output register by design
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         rvalid_o <= '0;
      end
      else
      begin
         for (int r = 0; r < XRF_RPORTS; r++)
         begin
            rvalid_o[r] <= rd_i[r].en;
         end
      end
   end

   // xor across banks recovers the last written word
   always_comb
   begin
      for (int r = 0; r < XRF_RPORTS; r++)
      begin
         rdata_o[r] = '0;
         for (int b = 0; b < XRF_WPORTS; b++)
         begin
            rdata_o[r] = rdata_o[r] ^ bank_rdata_i[b][r];
         end
      end
   end

endmodule

//--- verilog/xor_regfile.sv
module xor_regfile
   import xrf_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rstn,
   input  xrf_wr_req_t [XRF_WPORTS-1:0]         wr_i,
   input  xrf_rd_req_t [XRF_RPORTS-1:0]         rd_i,
   output logic [XRF_RPORTS-1:0][XRF_WIDTH-1:0] rdata_o,
   output logic [XRF_RPORTS-1:0]                rvalid_o
);

   logic [XRF_WPORTS-1:0][XRF_ADDR_W-1:0]                     wr_addr;
   logic [XRF_RPORTS-1:0][XRF_ADDR_W-1:0]                     rd_addr;
   xrf_ram_wr_t [XRF_WPORTS-1:0]                              ram_wr;
   logic [XRF_WPORTS-1:0][XRF_BYTES-1:0]                      ram_we;
   logic [XRF_WPORTS-1:0][XRF_LVT_COPIES-1:0][XRF_WIDTH-1:0]  copy_rdata;
   logic [XRF_WPORTS-1:0][XRF_LVT_COPIES-1:0][XRF_WIDTH-1:0]  enc_others;
   logic [XRF_WPORTS-1:0][XRF_RPORTS-1:0][XRF_WIDTH-1:0]      bank_rdata;

   generate
      // raw write addresses feed the copy reads of the other banks
      for (genvar p = 0; p < XRF_WPORTS; p++)
      begin : gen_wport
         assign wr_addr[p] = wr_i[p].addr;

         // k-th other bank returns its copy for writer p
         for (genvar k = 0; k < XRF_LVT_COPIES; k++)
         begin : gen_route
            assign enc_others[p][k] =
               copy_rdata[xrf_other(k, p)][xrf_copy_idx(p, xrf_other(k, p))];
         end

         xrf_write_encode u_enc
         (
            .clk      (clk),
            .rstn     (rstn),
            .wr_i     (wr_i[p]),
            .others_i (enc_others[p]),
            .ram_wr_o (ram_wr[p]),
            .we_o     (ram_we[p])
         );

         xrf_bank #(.BANK_ID(p)) u_bank
         (
            .clk          (clk),
            .ram_wr_i     (ram_wr[p]),
            .we_i         (ram_we[p]),
            .copy_raddr_i (wr_addr),
            .rd_addr_i    (rd_addr),
            .copy_rdata_o (copy_rdata[p]),
            .rd_rdata_o   (bank_rdata[p])
         );
      end

      for (genvar r = 0; r < XRF_RPORTS; r++)
      begin : gen_rport
         assign rd_addr[r] = rd_i[r].addr;
      end
   endgenerate

   xrf_read_decode u_dec
   (
      .clk          (clk),
      .rstn         (rstn),
      .rd_i         (rd_i),
      .bank_rdata_i (bank_rdata),
      .rdata_o      (rdata_o),
      .rvalid_o     (rvalid_o)
   );

endmodule

//--- bench/xor_regfile_props.sv
module xor_regfile_props
   import xrf_pkg::*;
(
   input logic                         clk,
   input logic                         rstn,
   input xrf_wr_req_t [XRF_WPORTS-1:0] wr_i,
   input xrf_rd_req_t [XRF_RPORTS-1:0] rd_i,
   input logic [XRF_RPORTS-1:0]        rvalid_i
);

   generate
      // two writers never target one address in one cycle
      for (genvar a = 0; a < XRF_WPORTS; a++)
      begin : gen_pair_a
         for (genvar b = a + 1; b < XRF_WPORTS; b++)
         begin : gen_pair_b
            a_no_addr_clash : assert property (@(posedge clk) disable iff (!rstn)
               !(wr_i[a].en && wr_i[b].en && (wr_i[a].addr == wr_i[b].addr)))
            else $error("write ports %0d and %0d hit one address in one cycle", a, b);
         end
      end

      // valid is the read enable one edge later
      for (genvar r = 0; r < XRF_RPORTS; r++)
      begin : gen_rvalid
         a_rvalid_follows : assert property (@(posedge clk)
            rstn |=> (rvalid_i[r] == $past(rd_i[r].en)))
         else $error("read port %0d valid does not follow its enable", r);
      end
   endgenerate

   a_rvalid_reset : assert property (@(posedge clk) !rstn |=> (rvalid_i == '0))
   else $error("read valid high while in reset");

endmodule

//--- bench/xor_regfile_tb.sv
module xor_regfile_tb
   import xrf_pkg::*;
();

   logic                                 clk = 1'b0;
   logic                                 rstn;
   xrf_wr_req_t [XRF_WPORTS-1:0]         wr_req;
   xrf_rd_req_t [XRF_RPORTS-1:0]         rd_req;
   logic [XRF_RPORTS-1:0][XRF_WIDTH-1:0] rdata;
   logic [XRF_RPORTS-1:0]                rvalid;

   // shadow of the committed words and the pipeline the model keeps
   logic [XRF_WIDTH-1:0]                 shadow [XRF_DEPTH];
   xrf_wr_req_t [XRF_WPORTS-1:0]         pend_wr;
   logic [XRF_RPORTS-1:0]                exp_rvalid;
   logic [XRF_RPORTS-1:0][XRF_WIDTH-1:0] exp_word;
   logic [31:0]                          lfsr_state;
   int                                   n_checks;
   int                                   n_errors;

   always #10 clk = ~clk;

   xor_regfile UUT
   (
      .clk      (clk),
      .rstn     (rstn),
      .wr_i     (wr_req),
      .rd_i     (rd_req),
      .rdata_o  (rdata),
      .rvalid_o (rvalid)
   );

   bind xor_regfile xor_regfile_props u_props
   (
      .clk      (clk),
      .rstn     (rstn),
      .wr_i     (wr_i),
      .rd_i     (rd_i),
      .rvalid_i (rvalid_o)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [XRF_WIDTH-1:0] merge_bytes(input logic [XRF_WIDTH-1:0] old_word,
                                                        input logic [XRF_WIDTH-1:0] new_word,
                                                        input logic [XRF_BYTES-1:0] bwe);
      logic [XRF_WIDTH-1:0] w;
      w = old_word;
      for (int b = 0; b < XRF_BYTES; b++)
      begin
         if (bwe[b])
         begin
            w[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return w;
   endfunction

   // word a read captured now returns
   function automatic logic [XRF_WIDTH-1:0] expected_word(input logic [XRF_ADDR_W-1:0] addr);
      return shadow[addr];
   endfunction

   // reads see the shadow before this edge's commit, then last edge's writes land
   always @(posedge clk)
   begin
      if (!rstn)
      begin
         exp_rvalid = '0;
         pend_wr    = '0;
      end
      else
      begin
         for (int r = 0; r < XRF_RPORTS; r++)
         begin
            exp_rvalid[r] = rd_req[r].en;
            exp_word[r]   = expected_word(rd_req[r].addr);
         end
         for (int p = 0; p < XRF_WPORTS; p++)
         begin
            if (pend_wr[p].en)
            begin
               shadow[pend_wr[p].addr] =
                  merge_bytes(shadow[pend_wr[p].addr], pend_wr[p].data, pend_wr[p].bwe);
            end
         end
         pend_wr = wr_req;
      end
   end

   always @(negedge clk)
   begin
      for (int r = 0; r < XRF_RPORTS; r++)
      begin
         n_checks++;
         assert (rvalid[r] === exp_rvalid[r])
         else
         begin
            $display("[ERROR] %0t rvalid_o[%0d] got %b expected %b",
                     $time, r, rvalid[r], exp_rvalid[r]);
            n_errors++;
         end
         if (exp_rvalid[r])
         begin
            n_checks++;
            assert (rdata[r] === exp_word[r])
            else
            begin
               $display("[ERROR] %0t rdata_o[%0d] got %h expected %h",
                        $time, r, rdata[r], exp_word[r]);
               n_errors++;
            end
         end
      end
   end

   task automatic check_word(input string name, input logic [XRF_WIDTH-1:0] got,
                             input logic [XRF_WIDTH-1:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   task automatic idle(input int n);
      wr_req = '0;
      rd_req = '0;
      repeat (n) @(negedge clk);
   endtask

   task automatic write_one(input int port, input logic [XRF_ADDR_W-1:0] addr,
                            input logic [XRF_BYTES-1:0] bwe, input logic [XRF_WIDTH-1:0] data);
      wr_req = '0;
      rd_req = '0;
      wr_req[port] = '{en: 1'b1, addr: addr, bwe: bwe, data: data};
      @(negedge clk);
   endtask

   task automatic write_pair(input logic [XRF_ADDR_W-1:0] a0, input logic [XRF_WIDTH-1:0] d0,
                             input logic [XRF_ADDR_W-1:0] a1, input logic [XRF_WIDTH-1:0] d1);
      rd_req = '0;
      wr_req[0] = '{en: 1'b1, addr: a0, bwe: '1, data: d0};
      wr_req[1] = '{en: 1'b1, addr: a1, bwe: '1, data: d1};
      @(negedge clk);
   endtask

   task automatic read_both(input logic [XRF_ADDR_W-1:0] a0, input logic [XRF_ADDR_W-1:0] a1);
      wr_req = '0;
      rd_req[0] = '{en: 1'b1, addr: a0};
      rd_req[1] = '{en: 1'b1, addr: a1};
      @(negedge clk);
   endtask

   task automatic wait_rvalid(input int port);
      int n;
      n = 0;
      wr_req = '0;
      rd_req = '0;
      while (rvalid[port] !== 1'b1 && n < 10)
      begin
         @(negedge clk);
         n++;
      end
      if (rvalid[port] !== 1'b1)
      begin
         $display("timeout while waiting for read port %0d to return data", port);
         n_errors++;
      end
   endtask

   task automatic random_traffic(input int cycles);
      xrf_wr_req_t [XRF_WPORTS-1:0] w;
      xrf_wr_req_t [XRF_WPORTS-1:0] prev;
      logic [31:0]                  v;
      prev = '0;
      for (int c = 0; c < cycles; c++)
      begin
         for (int p = 0; p < XRF_WPORTS; p++)
         begin
            v = rand_bits(1);
            w[p].en = v[0];
            v = rand_bits(XRF_ADDR_W);
            w[p].addr = v[XRF_ADDR_W-1:0];
            v = rand_bits(XRF_BYTES);
            w[p].bwe = v[XRF_BYTES-1:0];
            w[p].data = rand_bits(XRF_WIDTH);
            // another writer on this address one cycle back, or in this cycle
            for (int q = 0; q < XRF_WPORTS; q++)
            begin
               if (q != p && prev[q].en && prev[q].addr == w[p].addr)
                  w[p].en = 1'b0;
               if (q < p && w[q].en && w[q].addr == w[p].addr)
                  w[p].en = 1'b0;
            end
         end
         for (int r = 0; r < XRF_RPORTS; r++)
         begin
            v = rand_bits(1);
            rd_req[r].en = v[0];
            v = rand_bits(XRF_ADDR_W);
            rd_req[r].addr = v[XRF_ADDR_W-1:0];
         end
         wr_req = w;
         prev = w;
         @(negedge clk);
      end
   endtask

   initial
   begin
      lfsr_state = 32'hc9c94bfb;
      n_checks   = 0;
      n_errors   = 0;
      rstn       = 1'b0;
      wr_req     = '0;
      rd_req     = '0;
      pend_wr    = '0;
      exp_rvalid = '0;
      exp_word   = '0;
      // RAMs power up unknown and XOR would carry the X forever
      for (int a = 0; a < XRF_DEPTH; a++)
      begin
         shadow[a] = '0;
         UUT.gen_wport[0].u_bank.gen_copy[0].u_copy_ram.mem[a] = '0;
         UUT.gen_wport[0].u_bank.gen_read[0].u_read_ram.mem[a] = '0;
         UUT.gen_wport[0].u_bank.gen_read[1].u_read_ram.mem[a] = '0;
         UUT.gen_wport[1].u_bank.gen_copy[0].u_copy_ram.mem[a] = '0;
         UUT.gen_wport[1].u_bank.gen_read[0].u_read_ram.mem[a] = '0;
         UUT.gen_wport[1].u_bank.gen_read[1].u_read_ram.mem[a] = '0;
      end
      repeat (8) @(negedge clk);
      rstn = 1'b1;
      idle(3);

      // full word through port 0, read on both ports
      write_one(0, 6'd5, 4'hf, 32'hdeadbeef);
      idle(1);
      read_both(6'd5, 6'd5);
      wait_rvalid(0);

      // both writers in one cycle
      write_pair(6'd10, 32'h0123_4567, 6'd11, 32'h89ab_cdef);
      idle(1);
      read_both(6'd10, 6'd11);
      read_both(6'd11, 6'd10);
      wait_rvalid(1);

      // byte merges from alternating ports
      write_one(0, 6'd20, 4'hf, 32'h1122_3344);
      idle(1);
      write_one(1, 6'd20, 4'b0010, 32'haabb_ccdd);
      idle(1);
      write_one(0, 6'd20, 4'b1000, 32'h5566_7788);
      idle(1);
      write_one(1, 6'd20, 4'b0101, 32'h99ee_ff00);
      idle(1);
      read_both(6'd20, 6'd20);
      wait_rvalid(0);

      // read at the commit edge gets the old word
      write_one(1, 6'd30, 4'hf, 32'hcafe_f00d);
      idle(2);
      write_one(0, 6'd30, 4'hf, 32'h0bad_c0de);
      read_both(6'd30, 6'd30);
      check_word("rdata_o[0]", rdata[0], 32'hcafe_f00d);
      check_word("rdata_o[1]", rdata[1], 32'hcafe_f00d);
      read_both(6'd30, 6'd30);
      check_word("rdata_o[0]", rdata[0], 32'h0bad_c0de);
      check_word("rdata_o[1]", rdata[1], 32'h0bad_c0de);

      random_traffic(300);
      idle(4);

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- flist.f
verilog/xrf_pkg.sv
verilog/sdp_bwe_bram.sv
verilog/xrf_write_encode.sv
verilog/xrf_bank.sv
verilog/xrf_read_decode.sv
verilog/xor_regfile.sv
bench/xor_regfile_props.sv
bench/xor_regfile_tb.sv
